// File: test/ctrl_stim.txt
# kind flags priv tw mie nmi irqs pend lderr sterr instr instr_c pc lsu
# exp_cause exp_mtval exp_sel exp_nmi, flags = valid ill ecall ebrk mret wfi ferr plus2 comp
0 1C6 3 0 0 0 00000 0 0 0 00000013 0000 00001000 00000000 01 00001002 1 0
0 124 3 0 0 0 00000 0 0 0 00000013 0000 00002000 00000000 01 00002000 1 0
0 1E0 3 0 0 0 00000 0 0 0 DEADBEEF 0000 00003000 00000000 02 DEADBEEF 1 0
0 181 3 0 0 0 00000 0 0 0 FFFFFFFF 1234 00003004 00000000 02 00001234 1 0
0 160 3 0 0 0 00000 0 0 0 00000073 0000 00004000 00000000 0B 00000000 1 0
0 140 0 0 0 0 00000 0 0 0 00000073 0000 00004004 00000000 08 00000000 1 0
0 120 3 0 0 0 00000 0 0 0 00100073 0000 00004008 00000000 03 00000000 1 0
0 110 0 0 0 0 00000 0 0 0 30200073 0000 00005000 00000000 02 30200073 1 0
0 108 0 1 0 0 00000 0 0 0 10500073 0000 00005004 00000000 02 10500073 1 0
0 110 3 0 0 0 00000 0 0 0 30200073 0000 00005008 00000000 00 00000000 2 0
0 000 3 0 0 0 00000 0 1 0 00000000 0000 00000000 80000010 05 80000010 1 0
0 000 3 0 0 0 00000 0 0 1 00000000 0000 00000000 80000020 07 80000020 1 0
0 000 3 0 1 0 38208 1 0 0 00000000 0000 00000000 00000000 39 00000000 1 0
0 000 3 0 1 0 38000 1 0 0 00000000 0000 00000000 00000000 2B 00000000 1 0
0 000 3 0 1 0 30000 1 0 0 00000000 0000 00000000 00000000 23 00000000 1 0
0 000 3 0 1 0 10000 1 0 0 00000000 0000 00000000 00000000 27 00000000 1 0
0 000 3 0 1 0 04000 1 0 0 00000000 0000 00000000 00000000 3E 00000000 1 0
1 000 3 0 0 0 10000 1 0 0 00000000 0000 00000000 00000000 00 00000000 0 0
0 000 3 0 1 1 08000 1 0 0 00000000 0000 00000000 00000000 3F 00000000 1 1
0 110 3 0 0 0 00000 0 0 0 30200073 0000 00006000 00000000 00 00000000 2 0
2 108 3 0 1 0 10000 1 0 0 10500073 0000 00007000 00000000 27 00000000 1 0

// File: all.f
common/ctrl_pkg.sv
hdl/exc_detect.sv
hdl/irq_select.sv
fsm/ctrl_fsm.sv
hdl/core_ctrl.sv
test/core_ctrl_assert.sv
test/tb_core_ctrl.sv

// File: Makefile
# Verilator build of the core controller testbench

VERILATOR ?= verilator
TOP       ?= tb_core_ctrl
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

# the stim path is relative to the project root
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: test/tb_core_ctrl.sv
/*
  testbench for core_ctrl, scenarios come from test/ctrl_stim.txt
  run from the project root so the stim path resolves
  every scenario must leave the FSM in DECODE for the next one
*/
`timescale 1ns/1ps

module tb_core_ctrl;
  import ctrl_pkg::*;

  localparam int TIMEOUT = 50;

  logic       clk_i;
  logic       rst_ni;
  logic       fetch_enable_i;
  id_insn_t   insn_i;
  priv_lvl_e  priv_mode_i;
  logic       csr_mstatus_mie_i;
  logic       csr_mstatus_tw_i;
  logic       irq_nm_i;
  irq_req_t   irqs_i;
  logic       irq_pending_i;
  logic       stall_id_i;
  logic       lsu_req_in_id_i;
  logic       load_err_i;
  logic       store_err_i;
  xlen_t      lsu_addr_last_i;
  logic       ctrl_busy_o;
  logic       instr_req_o;
  logic       id_in_ready_o;
  logic       instr_valid_clear_o;
  logic       flush_id_o;
  logic       controller_run_o;
  logic       nmi_mode_o;
  pc_ctrl_t   pc_ctrl_o;
  csr_ctrl_t  csr_ctrl_o;

  // one stim line, all fields read as hex
  logic [31:0] s_kind, s_flags, s_priv, s_tw, s_mie, s_nmi, s_irqs, s_pend;
  logic [31:0] s_lderr, s_sterr, s_instr, s_instr_c, s_pc, s_lsu;
  logic [31:0] s_ecause, s_emtval, s_esel, s_enmi;

  core_ctrl dut0 (.*);

  // checks sit on the FSM, where the state is visible
  bind ctrl_fsm core_ctrl_assert u_assert (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .state_i             (state_q),
    .pc_ctrl_i           (pc_ctrl_o),
    .csr_ctrl_i          (csr_ctrl_o),
    .flush_id_i          (flush_id_o),
    .instr_valid_clear_i (instr_valid_clear_o),
    .id_in_ready_i       (id_in_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////
  // error handling
  ////////////////////

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_cause(string name, exc_cause_e got, exc_cause_e exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_xlen(string name, xlen_t got, xlen_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_sel(string name, pc_sel_e got, pc_sel_e exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_exc_sel(string name, exc_pc_sel_e got, exc_pc_sel_e exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s expected %h got %h", name, exp, got));
    end
  endtask

  // single control bits
  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s expected %h got %h", name, exp, got));
    end
  endtask

  ////////////////////
  // drivers
  ////////////////////

  task automatic clear_inputs();
    insn_i            = '0;
    priv_mode_i       = PRIV_LVL_M;
    csr_mstatus_mie_i = 1'b0;
    csr_mstatus_tw_i  = 1'b0;
    irq_nm_i          = 1'b0;
    irqs_i            = '0;
    irq_pending_i     = 1'b0;
    stall_id_i        = 1'b0;
    lsu_req_in_id_i   = 1'b0;
    load_err_i        = 1'b0;
    store_err_i       = 1'b0;
    lsu_addr_last_i   = '0;
  endtask

  task automatic drive_irqs();
    csr_mstatus_mie_i = s_mie[0];
    irq_nm_i          = s_nmi[0];
    irqs_i            = irq_req_t'(s_irqs[17:0]);
    irq_pending_i     = s_pend[0];
  endtask

  // flag column bit order matches the id_insn_t field order
  task automatic drive_insn();
    insn_i.valid           = s_flags[8];
    insn_i.illegal         = s_flags[7];
    insn_i.ecall           = s_flags[6];
    insn_i.ebrk            = s_flags[5];
    insn_i.mret            = s_flags[4];
    insn_i.wfi             = s_flags[3];
    insn_i.fetch_err       = s_flags[2];
    insn_i.fetch_err_plus2 = s_flags[1];
    insn_i.is_compressed   = s_flags[0];
    insn_i.instr           = s_instr;
    insn_i.instr_c         = s_instr_c[15:0];
    insn_i.pc              = s_pc;
    priv_mode_i            = priv_lvl_e'(s_priv[1:0]);
    csr_mstatus_tw_i       = s_tw[0];
    lsu_addr_last_i        = s_lsu;
  endtask

  // samples mid-cycle, returns with seen high in the redirect cycle
  task automatic wait_redirect(output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < TIMEOUT && !seen; n++) begin
      @(negedge clk_i);
      if (pc_ctrl_o.set) begin
        seen = 1'b1;
      end
    end
  endtask

  task automatic check_redirect();
    bit is_irq;
    // bit 5 of the cause marks an interrupt
    is_irq = s_ecause[5];
    check_sel("pc_ctrl.sel", pc_ctrl_o.sel, pc_sel_e'(s_esel[1:0]));
    check_cause("csr_ctrl.cause", csr_ctrl_o.cause, exc_cause_e'(s_ecause[5:0]));
    check_xlen("csr_ctrl.mtval", csr_ctrl_o.mtval, s_emtval);
    // ID never accepts in the redirect cycle
    check_flag("id_in_ready_o", id_in_ready_o, 1'b0);
    // exceptions and MRET go through FLUSH, interrupts do not
    check_flag("flush_id_o", flush_id_o, ~is_irq);
    if (pc_sel_e'(s_esel[1:0]) == PC_ERET) begin
      check_flag("csr_ctrl.restore_mret", csr_ctrl_o.restore_mret, 1'b1);
    end else begin
      check_flag("csr_ctrl.save_cause", csr_ctrl_o.save_cause, 1'b1);
      check_exc_sel("pc_ctrl.exc_sel", pc_ctrl_o.exc_sel,
                    is_irq ? EXC_PC_IRQ : EXC_PC_EXC);
      // interrupts save the IF pc, exceptions the faulting ID pc
      check_flag("csr_ctrl.save_if", csr_ctrl_o.save_if, is_irq);
      check_flag("csr_ctrl.save_id", csr_ctrl_o.save_id, ~is_irq);
    end
  endtask

  task automatic wait_sleep();
    int n;
    bit idle;
    idle = 1'b0;
    for (n = 0; n < TIMEOUT && !idle; n++) begin
      @(negedge clk_i);
      idle = ~ctrl_busy_o;
    end
    if (!idle) begin
      abort_run("timeout waiting for ctrl_busy_o to drop after WFI");
    end
  endtask

  ////////////////////
  // one scenario
  ////////////////////

  // kind 0 expects a redirect, kind 1 expects none, kind 2 is WFI then wake
  task automatic run_scenario();
    int  stalls;
    bit  seen;
    stalls = $urandom % 4;
    // plain instruction stalled in ID, irqs already pending
    insn_i.valid = 1'b1;
    stall_id_i   = 1'b1;
    if (s_kind != 2) begin
      drive_irqs();
    end
    repeat (stalls) begin
      @(negedge clk_i);
      check_flag("pc_ctrl.set during stall", pc_ctrl_o.set, 1'b0);
      @(posedge clk_i);
      #1;
    end
    // a memory access still in ID holds off the irq as well
    stall_id_i      = 1'b0;
    lsu_req_in_id_i = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_flag("pc_ctrl.set during lsu request", pc_ctrl_o.set, 1'b0);
      @(posedge clk_i);
      #1;
    end
    lsu_req_in_id_i = 1'b0;
    drive_insn();
    load_err_i  = s_lderr[0];
    store_err_i = s_sterr[0];
    // special requests keep the instruction in IF-ID for FLUSH
    if (s_kind == 2 || (s_kind == 0 && !s_ecause[5])) begin
      @(negedge clk_i);
      check_flag("instr_valid_clear_o on hold", instr_valid_clear_o, 1'b0);
      check_flag("id_in_ready_o on hold", id_in_ready_o, 1'b0);
    end
    // lsu errors are one cycle pulses
    if (s_lderr[0] || s_sterr[0]) begin
      @(posedge clk_i);
      #1;
      load_err_i  = 1'b0;
      store_err_i = 1'b0;
    end
    if (s_kind == 2) begin
      wait_sleep();
      @(posedge clk_i);
      #1;
      insn_i = '0;
      @(negedge clk_i);
      check_flag("ctrl_busy_o asleep", ctrl_busy_o, 1'b0);
      @(posedge clk_i);
      #1;
      drive_irqs();
      @(negedge clk_i);
      check_flag("ctrl_busy_o on wake", ctrl_busy_o, 1'b1);
    end
    wait_redirect(seen);
    if (s_kind == 1) begin
      if (seen) begin
        abort_run("redirect taken although none was expected");
      end
    end else begin
      if (!seen) begin
        abort_run("timeout waiting for pc_ctrl_o.set");
      end
      check_redirect();
    end
    @(posedge clk_i);
    #1;
    clear_inputs();
    check_flag("nmi_mode_o", nmi_mode_o, s_enmi[0]);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int    fd;
    int    n;
    int    count;
    string line;
    void'($urandom(89155));
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    count          = 0;
    clear_inputs();

    // boot address held through reset and until fetch enable
    repeat (5) begin
      @(negedge clk_i);
      check_flag("instr_req_o in reset", instr_req_o, 1'b0);
      check_flag("pc_ctrl.set in reset", pc_ctrl_o.set, 1'b1);
      check_sel("pc_ctrl.sel in reset", pc_ctrl_o.sel, PC_BOOT);
      check_flag("ctrl_busy_o in reset", ctrl_busy_o, 1'b1);
    end
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_flag("instr_req_o before enable", instr_req_o, 1'b0);
      check_flag("pc_ctrl.set before enable", pc_ctrl_o.set, 1'b1);
      check_sel("pc_ctrl.sel before enable", pc_ctrl_o.sel, PC_BOOT);
    end
    @(posedge clk_i);
    #1;
    fetch_enable_i = 1'b1;
    for (n = 0; n < TIMEOUT && !instr_req_o; n++) begin
      @(negedge clk_i);
    end
    if (!instr_req_o) begin
      abort_run("timeout waiting for instr_req_o after fetch enable");
    end
    for (n = 0; n < TIMEOUT && !controller_run_o; n++) begin
      @(negedge clk_i);
    end
    if (!controller_run_o) begin
      abort_run("timeout waiting for the controller to reach decode");
    end
    @(posedge clk_i);
    #1;

    fd = $fopen("test/ctrl_stim.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open test/ctrl_stim.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == 8'h23) begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  s_kind, s_flags, s_priv, s_tw, s_mie, s_nmi, s_irqs, s_pend,
                  s_lderr, s_sterr, s_instr, s_instr_c, s_pc, s_lsu,
                  s_ecause, s_emtval, s_esel, s_enmi);
      if (n != 18) begin
        abort_run($sformatf("malformed stim line: %s", line));
      end
      run_scenario();
      count++;
    end
    $fclose(fd);
    if (count == 0) begin
      abort_run("stim file held no scenarios");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  end

endmodule

// File: test/core_ctrl_assert.sv
/*
  concurrent checks on the controller outputs, bound to ctrl_fsm
  inactive while reset is asserted
*/
`timescale 1ns/1ps

module core_ctrl_assert (
  input logic                 clk_i,
  input logic                 rst_ni,
  input ctrl_pkg::ctrl_fsm_e  state_i,
  input ctrl_pkg::pc_ctrl_t   pc_ctrl_i,
  input ctrl_pkg::csr_ctrl_t  csr_ctrl_i,
  input logic                 flush_id_i,
  input logic                 instr_valid_clear_i,
  input logic                 id_in_ready_i
);
  import ctrl_pkg::*;

  // a saved cause always comes with a redirect
  cause_needs_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_ctrl_i.save_cause |-> pc_ctrl_i.set)
    else $error("save_cause without pc_ctrl.set");

  // flushing ID must also drop its valid bit
  flush_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_id_i |-> instr_valid_clear_i)
    else $error("flush_id without instr_valid_clear");

  // ID only accepts in the fetch and decode states
  ready_states: assert property (@(posedge clk_i) disable iff (!rst_ni)
    id_in_ready_i |-> (state_i == DECODE || state_i == FIRST_FETCH))
    else $error("id_in_ready outside DECODE and FIRST_FETCH");

endmodule

// File: hdl/core_ctrl.sv
/*
  core controller top, no debug mode and no writeback stage
  all control outputs are combinational from the FSM state
*/
`timescale 1ns/1ps

module core_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_enable_i,
  input  ctrl_pkg::id_insn_t   insn_i,
  input  ctrl_pkg::priv_lvl_e  priv_mode_i,
  input  logic                 csr_mstatus_mie_i,
  input  logic                 csr_mstatus_tw_i,
  input  logic                 irq_nm_i,
  input  ctrl_pkg::irq_req_t   irqs_i,
  input  logic                 irq_pending_i,
  input  logic                 stall_id_i,
  input  logic                 lsu_req_in_id_i,
  input  logic                 load_err_i,
  input  logic                 store_err_i,
  input  ctrl_pkg::xlen_t      lsu_addr_last_i,
  output logic                 ctrl_busy_o,
  output logic                 instr_req_o,
  output logic                 id_in_ready_o,
  output logic                 instr_valid_clear_o,
  output logic                 flush_id_o,
  output logic                 controller_run_o,
  output logic                 nmi_mode_o,
  output ctrl_pkg::pc_ctrl_t   pc_ctrl_o,
  output ctrl_pkg::csr_ctrl_t  csr_ctrl_o
);
  import ctrl_pkg::*;

  trap_t      trap;
  logic       special_req;
  logic       mret;
  logic       wfi;
  logic       handle_irq;
  exc_cause_e irq_cause;
  logic       in_flush;

  ////////////////////
  // input side
  ////////////////////

  exc_detect u_exc_detect (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .insn_i           (insn_i),
    .priv_mode_i      (priv_mode_i),
    .csr_mstatus_tw_i (csr_mstatus_tw_i),
    .load_err_i       (load_err_i),
    .store_err_i      (store_err_i),
    .lsu_addr_last_i  (lsu_addr_last_i),
    .in_flush_i       (in_flush),
    .trap_o           (trap),
    .special_req_o    (special_req),
    .mret_o           (mret),
    .wfi_o            (wfi)
  );

  // nmi mode feeds back to block nested interrupts
  irq_select u_irq_select (
    .irq_nm_i          (irq_nm_i),
    .irqs_i            (irqs_i),
    .irq_pending_i     (irq_pending_i),
    .csr_mstatus_mie_i (csr_mstatus_mie_i),
    .nmi_mode_i        (nmi_mode_o),
    .handle_irq_o      (handle_irq),
    .irq_cause_o       (irq_cause)
  );

  ////////////////////
  // state machine
  ////////////////////

  ctrl_fsm u_ctrl_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_enable_i      (fetch_enable_i),
    .insn_valid_i        (insn_i.valid),
    .trap_i              (trap),
    .special_req_i       (special_req),
    .mret_i              (mret),
    .wfi_i               (wfi),
    .handle_irq_i        (handle_irq),
    .irq_cause_i         (irq_cause),
    .irq_nm_i            (irq_nm_i),
    .irq_pending_i       (irq_pending_i),
    .stall_id_i          (stall_id_i),
    .lsu_req_in_id_i     (lsu_req_in_id_i),
    .in_flush_o          (in_flush),
    .nmi_mode_o          (nmi_mode_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .instr_req_o         (instr_req_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o),
    .controller_run_o    (controller_run_o),
    .pc_ctrl_o           (pc_ctrl_o),
    .csr_ctrl_o          (csr_ctrl_o)
  );

endmodule

// File: fsm/ctrl_fsm.sv
/*
  controller state machine with all pipeline and CSR control outputs
  outputs are combinational decodes of the current state and inputs
  single level of NMI only, a second NMI waits for MRET
*/
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  input  logic                  insn_valid_i,
  input  ctrl_pkg::trap_t       trap_i,
  input  logic                  special_req_i,
  input  logic                  mret_i,
  input  logic                  wfi_i,
  input  logic                  handle_irq_i,
  input  ctrl_pkg::exc_cause_e  irq_cause_i,
  input  logic                  irq_nm_i,
  input  logic                  irq_pending_i,
  input  logic                  stall_id_i,
  input  logic                  lsu_req_in_id_i,
  output logic                  in_flush_o,
  output logic                  nmi_mode_o,
  output logic                  ctrl_busy_o,
  output logic                  instr_req_o,
  output logic                  id_in_ready_o,
  output logic                  instr_valid_clear_o,
  output logic                  flush_id_o,
  output logic                  controller_run_o,
  output ctrl_pkg::pc_ctrl_t    pc_ctrl_o,
  output ctrl_pkg::csr_ctrl_t   csr_ctrl_o
);
  import ctrl_pkg::*;

  ctrl_fsm_e state_q, state_d;
  logic      nmi_mode_q, nmi_mode_d;
  logic      stall;
  logic      halt_if;
  logic      retain_id;
  logic      flush_id;

  // a stall only matters while ID holds a real instruction
  assign stall = stall_id_i & insn_valid_i;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d          = state_q;
    nmi_mode_d       = nmi_mode_q;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    controller_run_o = 1'b0;
    // IF only feeds ID in FIRST_FETCH and DECODE
    halt_if          = 1'b1;
    retain_id        = 1'b0;
    flush_id         = 1'b0;

    // sel and exc_sel only matter with set high
    pc_ctrl_o.set     = 1'b0;
    pc_ctrl_o.sel     = PC_BOOT;
    pc_ctrl_o.exc_sel = EXC_PC_IRQ;

    csr_ctrl_o.save_if      = 1'b0;
    csr_ctrl_o.save_id      = 1'b0;
    csr_ctrl_o.save_cause   = 1'b0;
    csr_ctrl_o.restore_mret = 1'b0;
    csr_ctrl_o.cause        = EXC_CAUSE_INSN_ADDR_MISA;
    csr_ctrl_o.mtval        = '0;

    unique case (state_q)
      RESET: begin
        // hold the boot address until fetch is enabled
        instr_req_o   = 1'b0;
        pc_ctrl_o.set = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      BOOT_SET: begin
        pc_ctrl_o.set = 1'b1;
        state_d       = FIRST_FETCH;
      end

      FIRST_FETCH: begin
        halt_if = 1'b0;
        // wait out an IF miss
        if (!stall) begin
          state_d = DECODE;
        end
        // keep this instruction, it may still have memory traffic
        if (handle_irq_i) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      DECODE: begin
        controller_run_o = 1'b1;
        halt_if          = 1'b0;
        if (special_req_i) begin
          // keep the instruction in ID so FLUSH can look at it
          retain_id = 1'b1;
          state_d   = FLUSH;
        end
        // let the current instruction finish before the irq
        if (handle_irq_i && (stall || lsu_req_in_id_i)) begin
          halt_if = 1'b1;
        end
        if (!stall && !lsu_req_in_id_i && !special_req_i && handle_irq_i) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      IRQ_TAKEN: begin
        pc_ctrl_o.sel     = PC_EXC;
        pc_ctrl_o.exc_sel = EXC_PC_IRQ;
        // request may have gone away, then just resume
        if (handle_irq_i) begin
          pc_ctrl_o.set         = 1'b1;
          csr_ctrl_o.save_if    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          csr_ctrl_o.cause      = irq_cause_i;
          if (irq_cause_i == EXC_CAUSE_IRQ_NM) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end

      FLUSH: begin
        flush_id = 1'b1;
        state_d  = DECODE;
        if (trap_i.pending) begin
          // mepc comes from the faulting instruction in ID
          pc_ctrl_o.set         = 1'b1;
          pc_ctrl_o.sel         = PC_EXC;
          pc_ctrl_o.exc_sel     = EXC_PC_EXC;
          csr_ctrl_o.save_id    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          csr_ctrl_o.cause      = trap_i.cause;
          csr_ctrl_o.mtval      = trap_i.mtval;
        end else if (mret_i) begin
          pc_ctrl_o.set           = 1'b1;
          pc_ctrl_o.sel           = PC_ERET;
          csr_ctrl_o.restore_mret = 1'b1;
          // leaving the NMI handler
          nmi_mode_d              = 1'b0;
        end else if (wfi_i) begin
          state_d = WAIT_SLEEP;
        end
      end

      WAIT_SLEEP: begin
        // one cycle to drain before the clock can stop
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        flush_id    = 1'b1;
        // wake on any pending irq, even with mie clear
        if (irq_nm_i || irq_pending_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////
  // stall control
  ////////////////////

  assign id_in_ready_o = ~stall & ~halt_if & ~retain_id;

  // retained or stalled instructions stay unless flushed
  assign instr_valid_clear_o = ~(stall | retain_id) | flush_id;
  assign flush_id_o          = flush_id;
  assign in_flush_o          = (state_q == FLUSH);
  assign nmi_mode_o          = nmi_mode_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

endmodule

// File: hdl/irq_select.sv
/*
  interrupt acceptance and cause encoding, purely combinational
  irqs_i must already be masked with the mie CSR
*/
`timescale 1ns/1ps

module irq_select (
  input  logic                  irq_nm_i,
  input  ctrl_pkg::irq_req_t    irqs_i,
  input  logic                  irq_pending_i,
  input  logic                  csr_mstatus_mie_i,
  input  logic                  nmi_mode_i,
  output logic                  handle_irq_o,
  output ctrl_pkg::exc_cause_e  irq_cause_o
);
  import ctrl_pkg::*;

  fast_id_t mfip_id;

  // no nesting inside the NMI handler, NMI ignores mie
  assign handle_irq_o = ~nmi_mode_i &
                        (irq_nm_i | (irq_pending_i & csr_mstatus_mie_i));

  // highest fast id wins, later hits overwrite earlier ones
  always_comb begin
    mfip_id = '0;
    for (int i = 0; i < 15; i++) begin
      if (irqs_i.fast[i]) begin
        mfip_id = fast_id_t'(i);
      end
    end
  end

  ////////////////////
  // cause encoding
  ////////////////////

  always_comb begin
    irq_cause_o = EXC_CAUSE_INSN_ADDR_MISA;
    if (irq_nm_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (irqs_i.fast != '0) begin
      // interrupt flag plus 16 gives the 0x30 base
      irq_cause_o = exc_cause_e'({2'b11, mfip_id});
    end else if (irqs_i.external) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.software) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else if (irqs_i.timer) begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

endmodule

// File: hdl/exc_detect.sv
/*
  synchronous exception detection and selection
  decoder flags are raw and get qualified with the valid bit here
  lsu errors are expected as single cycle pulses from the lsu
*/
`timescale 1ns/1ps

module exc_detect (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ctrl_pkg::id_insn_t   insn_i,
  input  ctrl_pkg::priv_lvl_e  priv_mode_i,
  input  logic                 csr_mstatus_tw_i,
  input  logic                 load_err_i,
  input  logic                 store_err_i,
  input  ctrl_pkg::xlen_t      lsu_addr_last_i,
  input  logic                 in_flush_i,
  output ctrl_pkg::trap_t      trap_o,
  output logic                 special_req_o,
  output logic                 mret_o,
  output logic                 wfi_o
);
  import ctrl_pkg::*;

  logic ecall_insn;
  logic ebrk_insn;
  logic mret_insn;
  logic wfi_insn;
  logic fetch_err;
  logic illegal_umode;
  logic illegal_insn_d, illegal_insn_q;
  logic exc_req_d, exc_req_q;
  logic load_err_q;
  logic store_err_q;

  ////////////////////
  // qualify flags
  ////////////////////

  // decoder output only counts with a valid instruction in ID
  assign ecall_insn = insn_i.ecall & insn_i.valid;
  assign ebrk_insn  = insn_i.ebrk & insn_i.valid;
  assign mret_insn  = insn_i.mret & insn_i.valid;
  assign wfi_insn   = insn_i.wfi & insn_i.valid;
  assign fetch_err  = insn_i.fetch_err & insn_i.valid;

  // mret needs M-mode, wfi traps in U-mode when TW is set
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) &
                         (mret_insn | (csr_mstatus_tw_i & wfi_insn));

  // both request flops drop while the flush handles them
  assign illegal_insn_d = ((insn_i.illegal & insn_i.valid) | illegal_umode) & ~in_flush_i;
  assign exc_req_d      = (ecall_insn | ebrk_insn | illegal_insn_d | fetch_err) & ~in_flush_i;

  // anything that needs the FLUSH state
  assign special_req_o = mret_insn | wfi_insn | exc_req_d | load_err_i | store_err_i;
  assign mret_o        = mret_insn;
  assign wfi_o         = wfi_insn;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_insn_q <= 1'b0;
      exc_req_q      <= 1'b0;
      load_err_q     <= 1'b0;
      store_err_q    <= 1'b0;
    end else begin
      illegal_insn_q <= illegal_insn_d;
      exc_req_q      <= exc_req_d;
      load_err_q     <= load_err_i;
      store_err_q    <= store_err_i;
    end
  end

  ////////////////////
  // priority select
  ////////////////////

  assign trap_o.pending = exc_req_q | store_err_q | load_err_q;

  // order per privileged spec table, ID faults before lsu faults
  always_comb begin
    trap_o.cause = EXC_CAUSE_INSN_ADDR_MISA;
    trap_o.mtval = '0;
    if (fetch_err) begin
      trap_o.cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
      // fault on the upper half of a 32-bit instruction
      trap_o.mtval = insn_i.fetch_err_plus2 ? (insn_i.pc + 32'd2) : insn_i.pc;
    end else if (illegal_insn_q) begin
      trap_o.cause = EXC_CAUSE_ILLEGAL_INSN;
      trap_o.mtval = insn_i.is_compressed ? {16'b0, insn_i.instr_c} : insn_i.instr;
    end else if (ecall_insn) begin
      trap_o.cause = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE :
                                                   EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk_insn) begin
      trap_o.cause = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      trap_o.cause = EXC_CAUSE_STORE_ACCESS_FAULT;
      trap_o.mtval = lsu_addr_last_i;
    end else if (load_err_q) begin
      trap_o.cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
      trap_o.mtval = lsu_addr_last_i;
    end
  end

endmodule

// File: common/ctrl_pkg.sv
/*
  shared types for the core controller and its testbench
  privilege levels cover M and U only, no S-mode support
  exception and interrupt codes follow the RISC-V privileged spec
*/
package ctrl_pkg;

  ////////////////////
  // vector types
  ////////////////////

  // data word or address
  typedef logic [31:0] xlen_t;
  // raw compressed instruction
  typedef logic [15:0] insn_c_t;
  // one bit per fast interrupt line
  typedef logic [14:0] fast_irq_t;
  // fast interrupt index
  typedef logic [3:0]  fast_id_t;

  ////////////////////
  // enums
  ////////////////////

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // prefetcher address source
  typedef enum logic [1:0] {
    PC_BOOT = 2'd0,
    PC_EXC  = 2'd1,
    PC_ERET = 2'd2
  } pc_sel_e;

  // trap vector offset select
  typedef enum logic {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

  // bit 5 set marks an interrupt, fast irq n is 0x30 + n
  typedef enum logic [5:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = 6'h00,
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'h01,
    EXC_CAUSE_ILLEGAL_INSN       = 6'h02,
    EXC_CAUSE_BREAKPOINT         = 6'h03,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'h05,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'h07,
    EXC_CAUSE_ECALL_UMODE        = 6'h08,
    EXC_CAUSE_ECALL_MMODE        = 6'h0B,
    EXC_CAUSE_IRQ_SOFTWARE_M     = 6'h23,
    EXC_CAUSE_IRQ_TIMER_M        = 6'h27,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 6'h2B,
    EXC_CAUSE_IRQ_NM             = 6'h3F
  } exc_cause_e;

  // controller states, visible here for the bound checks
  typedef enum logic [3:0] {
    RESET, BOOT_SET, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN, WAIT_SLEEP, SLEEP
  } ctrl_fsm_e;

  ////////////////////
  // bundles
  ////////////////////

  // contents of the IF-ID register plus decoder flags
  typedef struct packed {
    logic    valid;
    logic    illegal;
    logic    ecall;
    logic    ebrk;
    logic    mret;
    logic    wfi;
    logic    fetch_err;
    logic    fetch_err_plus2;
    logic    is_compressed;
    xlen_t   instr;
    insn_c_t instr_c;
    xlen_t   pc;
  } id_insn_t;

  // requests already masked with mie
  typedef struct packed {
    logic      software;
    logic      timer;
    logic      external;
    fast_irq_t fast;
  } irq_req_t;

  typedef struct packed {
    logic       pending;
    exc_cause_e cause;
    xlen_t      mtval;
  } trap_t;

  typedef struct packed {
    logic        set;
    pc_sel_e     sel;
    exc_pc_sel_e exc_sel;
  } pc_ctrl_t;

  typedef struct packed {
    logic       save_if;
    logic       save_id;
    logic       save_cause;
    logic       restore_mret;
    exc_cause_e cause;
    xlen_t      mtval;
  } csr_ctrl_t;

endpackage
